// File: hdl/sq_pkg.sv
// shared widths, size encoding and packed structs for the store path
// referenced by scoped name from every module in hdl/

package sq_pkg;

    ////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////
    localparam int xlen       = 32;
    localparam int prf_len    = 6;   // physical register tag
    localparam int rob_len    = 5;
    localparam int imm_len    = 12;  // s-type immediate
    localparam int rs_sq_size = 8;
    localparam int rs_sq_len  = 3;
    localparam int sq_size    = 8;
    localparam int sq_len     = 3;

    typedef enum logic [1:0] {
        mem_byte = 2'h0,
        mem_half = 2'h1,
        mem_word = 2'h2
    } mem_size_t;

    ////////////////////////////////////////
    // packets
    ////////////////////////////////////////

    // one store as handed over by dispatch
    typedef struct packed {
        logic [prf_len-1:0] base_tag;
        logic               base_ready;
        logic [prf_len-1:0] src_tag;
        logic               src_ready;
        logic [xlen-1:0]    base_value;  // only meaningful with base_ready
        logic [xlen-1:0]    src_value;   // only meaningful with src_ready
        logic [imm_len-1:0] offset;
        mem_size_t          mem_size;
        logic [rob_len-1:0] rob_idx;
        logic [sq_len-1:0]  sq_idx;
    } sq_dispatch_t;

    // station entry, operand fields hold the tag until ready and the value after
    typedef struct packed {
        logic               base_ready;
        logic [xlen-1:0]    base;
        logic               src_ready;
        logic [xlen-1:0]    src;
        logic [imm_len-1:0] offset;
        mem_size_t          mem_size;
        logic [rob_len-1:0] rob_idx;
        logic [sq_len-1:0]  sq_idx;
    } rs_sq_entry_t;

    typedef struct packed {
        logic               valid;
        logic [prf_len-1:0] tag;
        logic [xlen-1:0]    value;
    } cdb_t;

    typedef struct packed {
        logic [xlen-1:0]   word_addr;  // low two bits always zero
        logic [xlen/8-1:0] strobe;
        logic [xlen-1:0]   data;       // already shifted into its byte lanes
        logic [sq_len-1:0] sq_idx;
    } agen_result_t;

    typedef struct packed {
        logic [xlen-1:0]   word_addr;
        logic [xlen/8-1:0] strobe;
        logic [xlen-1:0]   data;
    } mem_write_t;

endpackage

// File: hdl/psel_gen.sv
// fixed priority selector, lowest index wins
// gives a one-hot grant plus a flag for an all-zero request vector

`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt,
    output logic             empty
);

    logic [WIDTH-1:0] higher;  // set where some lower request already won

    always_comb begin
        higher[0] = 1'b0;
        for (int i = 1; i < WIDTH; i++) begin
            higher[i] = higher[i-1] | req[i-1];
        end
    end

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            gnt[i] = req[i] & ~higher[i];
        end
    end

    assign empty = ~|req;

endmodule

// File: hdl/rs_sq.sv
// store reservation station, holds dispatched stores until both operands
// arrive from dispatch or the CDB, then issues one per cycle to address gen

`timescale 1ns/1ps

module rs_sq (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 dispatch_valid,
    input  sq_pkg::sq_dispatch_t dispatch,
    input  sq_pkg::cdb_t         cdb,
    output logic                 issue_valid,
    output sq_pkg::rs_sq_entry_t issue,
    output logic                 rs_full
);

    sq_pkg::rs_sq_entry_t [sq_pkg::rs_sq_size-1:0] entries;

    logic [sq_pkg::rs_sq_size-1:0] free;     // slot holds no store
    logic [sq_pkg::rs_sq_len:0]    count;
    logic [sq_pkg::rs_sq_size-1:0] ready;    // occupied with both operands in
    logic [sq_pkg::rs_sq_size-1:0] gnt;
    logic                          none_ready;
    logic [sq_pkg::rs_sq_len-1:0]  free_idx;
    logic [sq_pkg::rs_sq_len-1:0]  issue_idx;
    logic                          base_hit;
    logic                          src_hit;
    sq_pkg::rs_sq_entry_t          new_entry;

    assign rs_full = (count == sq_pkg::rs_sq_size);

    ////////////////////////////////////////
    // slot search and issue select
    ////////////////////////////////////////

    // lowest free slot, walking down so the last hit is the smallest index
    always_comb begin
        free_idx = '0;
        for (int i = sq_pkg::rs_sq_size - 1; i >= 0; i--) begin
            if (free[i]) free_idx = i[sq_pkg::rs_sq_len-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < sq_pkg::rs_sq_size; i++) begin
            ready[i] = ~free[i] & entries[i].base_ready & entries[i].src_ready;
        end
    end

    psel_gen #(.WIDTH(sq_pkg::rs_sq_size)) psel (
        .req   (ready),
        .gnt   (gnt),
        .empty (none_ready)
    );

    always_comb begin
        issue_idx = '0;
        for (int i = 0; i < sq_pkg::rs_sq_size; i++) begin
            if (gnt[i]) issue_idx = i[sq_pkg::rs_sq_len-1:0];
        end
    end

    ////////////////////////////////////////
    // incoming entry
    ////////////////////////////////////////

    // a broadcast in the dispatch cycle must not be missed
    assign base_hit = cdb.valid && (cdb.tag == dispatch.base_tag);
    assign src_hit  = cdb.valid && (cdb.tag == dispatch.src_tag);

    always_comb begin
        new_entry.base_ready = dispatch.base_ready | base_hit;
        if (dispatch.base_ready)
            new_entry.base = dispatch.base_value;
        else if (base_hit)
            new_entry.base = cdb.value;
        else
            new_entry.base = {{(sq_pkg::xlen - sq_pkg::prf_len){1'b0}}, dispatch.base_tag};

        new_entry.src_ready = dispatch.src_ready | src_hit;
        if (dispatch.src_ready)
            new_entry.src = dispatch.src_value;
        else if (src_hit)
            new_entry.src = cdb.value;
        else
            new_entry.src = {{(sq_pkg::xlen - sq_pkg::prf_len){1'b0}}, dispatch.src_tag};

        new_entry.offset   = dispatch.offset;
        new_entry.mem_size = dispatch.mem_size;
        new_entry.rob_idx  = dispatch.rob_idx;
        new_entry.sq_idx   = dispatch.sq_idx;
    end

    ////////////////////////////////////////
    // state
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            free        <= '1;
            count       <= '0;
            issue_valid <= 1'b0;
        end else if (flush) begin
            free        <= '1;  // drop every waiting store
            count       <= '0;
            issue_valid <= 1'b0;
        end else begin
            count <= count + {{sq_pkg::rs_sq_len{1'b0}}, dispatch_valid}
                           - {{sq_pkg::rs_sq_len{1'b0}}, ~none_ready};
            issue_valid <= ~none_ready;
            if (dispatch_valid) free[free_idx] <= 1'b0;
            if (!none_ready) free[issue_idx] <= 1'b1;  // never the dispatch slot
        end
    end

    always_ff @(posedge clock) begin
        if (!none_ready) issue <= entries[issue_idx];

        for (int i = 0; i < sq_pkg::rs_sq_size; i++) begin
            if (dispatch_valid && (int'(free_idx) == i)) begin
                entries[i] <= new_entry;
            end else if (cdb.valid && !free[i]) begin
                // wake up on tag match
                if (!entries[i].base_ready &&
                    (entries[i].base[sq_pkg::prf_len-1:0] == cdb.tag)) begin
                    entries[i].base_ready <= 1'b1;
                    entries[i].base       <= cdb.value;
                end
                if (!entries[i].src_ready &&
                    (entries[i].src[sq_pkg::prf_len-1:0] == cdb.tag)) begin
                    entries[i].src_ready <= 1'b1;
                    entries[i].src       <= cdb.value;
                end
            end
        end
    end

endmodule

// File: hdl/store_agen.sv
// address stage for stores, one register deep with no back-pressure
// produces word address, byte strobe and lane-aligned data

`timescale 1ns/1ps

module store_agen (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  sq_pkg::rs_sq_entry_t issue,
    output logic                 agen_valid,
    output sq_pkg::agen_result_t agen
);

    logic [sq_pkg::xlen-1:0]   eff_addr;
    logic [1:0]                lane;      // byte lane within the word
    logic [sq_pkg::xlen/8-1:0] strobe;
    logic [sq_pkg::xlen-1:0]   lane_data;

    assign eff_addr = issue.base
                    + {{(sq_pkg::xlen - sq_pkg::imm_len){issue.offset[sq_pkg::imm_len-1]}},
                       issue.offset};
    assign lane = eff_addr[1:0];

    // misaligned low bits are dropped for the access size
    always_comb begin
        case (issue.mem_size)
            sq_pkg::mem_byte: begin
                strobe    = 4'b0001 << lane;
                lane_data = issue.src << {lane, 3'b000};
            end
            sq_pkg::mem_half: begin
                strobe    = lane[1] ? 4'b1100 : 4'b0011;  // lane bit 0 ignored
                lane_data = issue.src << {lane[1], 4'b0000};
            end
            default: begin
                strobe    = 4'b1111;
                lane_data = issue.src;
            end
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            agen_valid <= 1'b0;
        else
            agen_valid <= issue_valid;
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            agen.word_addr <= {eff_addr[sq_pkg::xlen-1:2], 2'b00};
            agen.strobe    <= strobe;
            agen.data      <= lane_data;
            agen.sq_idx    <= issue.sq_idx;
        end
    end

endmodule

// File: hdl/store_queue.sv
// circular store queue, slots allocated at dispatch and filled by address gen
// committed stores drain in order over a four-phase req/ack memory port

`timescale 1ns/1ps

module store_queue (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      alloc,
    output logic [sq_pkg::sq_len-1:0] alloc_idx,
    output logic                      sq_full,
    input  logic                      agen_valid,
    input  sq_pkg::agen_result_t      agen,
    input  logic                      commit,
    output logic                      mem_req,
    input  logic                      mem_ack,
    output sq_pkg::mem_write_t        mem_write
);

    typedef enum logic [1:0] {
        mem_idle    = 2'h0,
        mem_wait    = 2'h1,  // req high, waiting for ack
        mem_release = 2'h2   // req low, waiting for ack to drop
    } mem_state_t;

    sq_pkg::mem_write_t [sq_pkg::sq_size-1:0] slots;

    logic [sq_pkg::sq_size-1:0] computed;
    logic [sq_pkg::sq_len-1:0]  head;
    logic [sq_pkg::sq_len-1:0]  tail;
    logic [sq_pkg::sq_len:0]    count;       // allocated entries
    logic [sq_pkg::sq_len:0]    commit_cnt;  // committed, not yet written
    logic [sq_pkg::sq_len-1:0]  head_nxt;
    logic [sq_pkg::sq_len:0]    commit_nxt;
    logic                       head_ready;
    logic                       retire;
    mem_state_t                 state;

    assign alloc_idx = tail;
    assign sq_full   = (count == sq_pkg::sq_size);
    assign mem_write = slots[head];  // head holds still for the whole handshake

    assign head_ready = (commit_cnt != '0) && computed[head];
    assign retire     = (state == mem_release) && !mem_ack;
    assign head_nxt   = head + {{(sq_pkg::sq_len-1){1'b0}}, retire};
    assign commit_nxt = commit_cnt + {{sq_pkg::sq_len{1'b0}}, commit}
                                   - {{sq_pkg::sq_len{1'b0}}, retire};

    ////////////////////////////////////////
    // memory handshake
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= mem_idle;
            mem_req <= 1'b0;
        end else begin
            case (state)
                mem_idle: if (head_ready) begin
                    state   <= mem_wait;
                    mem_req <= 1'b1;
                end
                mem_wait: if (mem_ack) begin
                    state   <= mem_release;
                    mem_req <= 1'b0;
                end
                mem_release: if (!mem_ack) state <= mem_idle;  // write done
                default: begin
                    state   <= mem_idle;
                    mem_req <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // pointers and counters
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            commit_cnt <= '0;
        end else begin
            head       <= head_nxt;
            commit_cnt <= commit_nxt;
            if (flush) begin
                // keep only what the ROB has committed
                tail  <= head_nxt + commit_nxt[sq_pkg::sq_len-1:0];
                count <= commit_nxt;
            end else begin
                if (alloc) tail <= tail + 1'b1;
                count <= count + {{sq_pkg::sq_len{1'b0}}, alloc}
                               - {{sq_pkg::sq_len{1'b0}}, retire};
            end
        end
    end

    // a late result for a flushed slot loses to a fresh allocation
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            computed <= '0;
        end else begin
            if (agen_valid) computed[agen.sq_idx] <= 1'b1;
            if (alloc && !flush) computed[tail] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (agen_valid) begin
            slots[agen.sq_idx].word_addr <= agen.word_addr;
            slots[agen.sq_idx].strobe    <= agen.strobe;
            slots[agen.sq_idx].data      <= agen.data;
        end
    end

endmodule

// File: hdl/store_unit_top.sv
// store path top, reservation station into address gen into store queue
// dispatch_valid doubles as the queue allocate pulse

`timescale 1ns/1ps

module store_unit_top (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      dispatch_valid,
    input  sq_pkg::sq_dispatch_t      dispatch,
    input  sq_pkg::cdb_t              cdb,
    input  logic                      commit,
    output logic [sq_pkg::sq_len-1:0] alloc_idx,
    output logic                      rs_full,
    output logic                      sq_full,
    output logic                      mem_req,
    input  logic                      mem_ack,
    output sq_pkg::mem_write_t        mem_write
);

    logic                 issue_valid;
    sq_pkg::rs_sq_entry_t issue;
    logic                 agen_valid;
    sq_pkg::agen_result_t agen;

    rs_sq u_rs_sq (
        .clock          (clock),
        .rst_n          (rst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .rs_full        (rs_full)
    );

    store_agen u_store_agen (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .agen_valid  (agen_valid),
        .agen        (agen)
    );

    store_queue u_store_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .flush      (flush),
        .alloc      (dispatch_valid),
        .alloc_idx  (alloc_idx),
        .sq_full    (sq_full),
        .agen_valid (agen_valid),
        .agen       (agen),
        .commit     (commit),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_write  (mem_write)
    );

endmodule

// File: tb/tb_store_unit.sv
// directed testbench for the store path top level
// drives dispatch, CDB, commit and flush, answers the memory port
// and checks every write against a model built from the address rules

`timescale 1ns/1ps

module tb_store_unit;

    localparam int test_count      = 7;
    localparam int watchdog_cycles = test_count * 200;

    logic                      clock;
    logic                      rst_n;
    logic                      flush;
    logic                      dispatch_valid;
    sq_pkg::sq_dispatch_t      dispatch;
    sq_pkg::cdb_t              cdb;
    logic                      commit;
    logic [sq_pkg::sq_len-1:0] alloc_idx;
    logic                      rs_full;
    logic                      sq_full;
    logic                      mem_req;
    logic                      mem_ack;
    sq_pkg::mem_write_t        mem_write;

    sq_pkg::mem_write_t pend_q[$];  // dispatched but not yet committed
    sq_pkg::mem_write_t exp_q[$];   // committed stores in program order
    integer seed = 55;
    int     ack_delay;
    int     err_cnt  = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    logic [sq_pkg::rob_len-1:0] rob_next   = '0;
    logic [sq_pkg::sq_len-1:0]  tail_model = '0;  // expected queue tail

    store_unit_top dut (.*);

    initial clock = 1'b0;
    always #2 clock = ~clock;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic sq_pkg::mem_write_t calc_write(
        input logic [31:0]       base,
        input logic [11:0]       off,
        input sq_pkg::mem_size_t size,
        input logic [31:0]       src
    );
        logic [31:0]        addr;
        sq_pkg::mem_write_t w;
        addr        = base + {{20{off[11]}}, off};
        w.word_addr = {addr[31:2], 2'b00};
        case (size)
            sq_pkg::mem_byte: begin
                w.strobe = 4'b0001 << addr[1:0];
                w.data   = {24'h0, src[7:0]} << (8 * addr[1:0]);
            end
            sq_pkg::mem_half: begin
                w.strobe = addr[1] ? 4'b1100 : 4'b0011;  // odd byte address rounds down
                w.data   = addr[1] ? {src[15:0], 16'h0} : {16'h0, src[15:0]};
            end
            default: begin
                w.strobe = 4'b1111;
                w.data   = src;
            end
        endcase
        return w;
    endfunction

    function automatic logic [31:0] byte_mask(input logic [3:0] strobe);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) m[8*i +: 8] = {8{strobe[i]}};
        return m;
    endfunction

    // only the strobed lanes of the data reach memory
    task automatic check_write();
        sq_pkg::mem_write_t exp;
        logic [31:0]        mask;
        if (exp_q.size() == 0) begin
            $display("memory write to %h with no committed store outstanding",
                     mem_write.word_addr);
            err_cnt++;
            return;
        end
        exp  = exp_q.pop_front();
        mask = byte_mask(exp.strobe);
        if (mem_write.word_addr !== exp.word_addr) begin
            $display("ERROR mem_write.word_addr expected %h actual %h",
                     exp.word_addr, mem_write.word_addr);
            err_cnt++;
        end
        if (mem_write.strobe !== exp.strobe) begin
            $display("ERROR mem_write.strobe expected %h actual %h",
                     exp.strobe, mem_write.strobe);
            err_cnt++;
        end
        if ((mem_write.data & mask) !== (exp.data & mask)) begin
            $display("ERROR mem_write.data expected %h actual %h",
                     exp.data & mask, mem_write.data & mask);
            err_cnt++;
        end
    endtask

    // memory model acks each request after 0 to 3 cycles
    always begin
        @(negedge clock);
        if (mem_req && !mem_ack) begin
            ack_delay = $unsigned($random(seed)) % 4;
            repeat (ack_delay) @(negedge clock);
            check_write();
            mem_ack = 1'b1;
            while (mem_req) @(negedge clock);
            mem_ack = 1'b0;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////
    // driver tasks
    ////////////////////////////////////////

    task automatic send_store(
        input logic                       base_ready,
        input logic [sq_pkg::prf_len-1:0] base_tag,
        input logic [31:0]                base_value,
        input logic                       src_ready,
        input logic [sq_pkg::prf_len-1:0] src_tag,
        input logic [31:0]                src_value,
        input logic [11:0]                offset,
        input sq_pkg::mem_size_t          size
    );
        int n;
        n = 0;
        while ((rs_full || sq_full) && n < 50) begin
            @(negedge clock);
            n++;
        end
        if (rs_full || sq_full) begin
            $display("dispatch blocked, station or queue stayed full");
            err_cnt++;
            return;
        end
        dispatch.base_tag   = base_tag;
        dispatch.base_ready = base_ready;
        dispatch.src_tag    = src_tag;
        dispatch.src_ready  = src_ready;
        dispatch.base_value = base_ready ? base_value : ~base_value;  // stale when not ready
        dispatch.src_value  = src_ready ? src_value : ~src_value;
        dispatch.offset     = offset;
        dispatch.mem_size   = size;
        dispatch.rob_idx    = rob_next;
        dispatch.sq_idx     = alloc_idx;
        dispatch_valid      = 1'b1;
        rob_next++;
        tail_model++;
        pend_q.push_back(calc_write(base_value, offset, size, src_value));
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    task automatic commit_one();
        if (pend_q.size() == 0) begin
            $display("commit requested with no dispatched store outstanding");
            err_cnt++;
            return;
        end
        exp_q.push_back(pend_q.pop_front());
        commit = 1'b1;
        @(negedge clock);
        commit = 1'b0;
    endtask

    task automatic broadcast(input logic [sq_pkg::prf_len-1:0] tag, input logic [31:0] value);
        cdb.valid = 1'b1;
        cdb.tag   = tag;
        cdb.value = value;
        @(negedge clock);
        cdb.valid = 1'b0;
    endtask

    task automatic do_flush();
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        tail_model = tail_model - 3'(pend_q.size());  // tail falls back over dropped stores
        pend_q.delete();  // uncommitted stores are gone
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || mem_req || mem_ack) && n < 150) begin
            @(negedge clock);
            n++;
        end
        if (exp_q.size() != 0 || mem_req || mem_ack) begin
            $display("timed out with %0d committed stores not written", exp_q.size());
            err_cnt++;
        end
        @(negedge clock);  // last ack release retires the head
    endtask

    task automatic finish_test(input string name, input int start_err);
        if (err_cnt == start_err) begin
            pass_cnt++;
            $display("PASS  %s", name);
        end else begin
            fail_cnt++;
            $display("FAIL  %s (%0d errors)", name, err_cnt - start_err);
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_after_reset();
        int start_err;
        start_err = err_cnt;
        if (rs_full !== 1'b0) begin
            $display("ERROR rs_full expected %h actual %h", 1'b0, rs_full);
            err_cnt++;
        end
        if (sq_full !== 1'b0) begin
            $display("ERROR sq_full expected %h actual %h", 1'b0, sq_full);
            err_cnt++;
        end
        if (alloc_idx !== 3'h0) begin
            $display("ERROR alloc_idx expected %h actual %h", 3'h0, alloc_idx);
            err_cnt++;
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge clock);
            if (mem_req !== 1'b0) begin
                $display("ERROR mem_req expected %h actual %h", 1'b0, mem_req);
                err_cnt++;
            end
        end
        finish_test("idle after reset", start_err);
    endtask

    task automatic test_ready_sizes();
        int                start_err;
        logic [11:0]       off;
        logic [31:0]       base;
        sq_pkg::mem_size_t size;
        start_err = err_cnt;
        for (int i = 0; i < 8; i++) begin
            off  = (i == 7) ? 12'hffd : 12'(i * 3);  // last one has a negative offset
            base = 32'h0000_2000 + 32'(i * 64);
            size = sq_pkg::mem_size_t'(i % 3);
            send_store(1'b1, '0, base, 1'b1, '0, $random(seed), off, size);
            commit_one();
        end
        wait_drain();
        finish_test("ready operands at each size", start_err);
    endtask

    task automatic test_cdb_wakeup();
        int          start_err;
        logic [31:0] val [4];
        start_err = err_cnt;
        for (int i = 0; i < 4; i++) val[i] = $random(seed);
        send_store(1'b0, 6'd10, val[0], 1'b0, 6'd11, val[1], 12'h004, sq_pkg::mem_word);
        send_store(1'b0, 6'd12, val[2], 1'b0, 6'd13, val[3], 12'h007, sq_pkg::mem_byte);
        repeat (3) @(negedge clock);
        broadcast(6'd10, val[0]);  // base first
        broadcast(6'd11, val[1]);
        broadcast(6'd13, val[3]);  // source first
        broadcast(6'd12, val[2]);
        commit_one();
        commit_one();
        wait_drain();
        finish_test("CDB wake-up in either order", start_err);
    endtask

    task automatic test_rs_full();
        int          start_err;
        int          n;
        logic [31:0] base_val [8];
        start_err = err_cnt;
        for (int i = 0; i < 8; i++) begin
            base_val[i] = $random(seed);
            send_store(1'b0, 6'(20 + i), base_val[i], 1'b1, '0, $random(seed),
                       12'(i * 4), sq_pkg::mem_word);
        end
        if (rs_full !== 1'b1) begin
            $display("ERROR rs_full expected %h actual %h", 1'b1, rs_full);
            err_cnt++;
        end
        if (sq_full !== 1'b1) begin
            $display("ERROR sq_full expected %h actual %h", 1'b1, sq_full);
            err_cnt++;
        end
        broadcast(6'd20, base_val[0]);
        n = 0;
        while (rs_full && n < 10) begin
            @(negedge clock);
            n++;
        end
        if (rs_full) begin
            $display("rs_full stayed high after one store woke up and issued");
            err_cnt++;
        end
        for (int i = 1; i < 8; i++) broadcast(6'(20 + i), base_val[i]);
        for (int i = 0; i < 8; i++) commit_one();
        wait_drain();
        finish_test("station full and release", start_err);
    endtask

    task automatic test_reverse_wakeup();
        int          start_err;
        logic [31:0] src_val [4];
        start_err = err_cnt;
        for (int i = 0; i < 4; i++) begin
            src_val[i] = $random(seed);
            send_store(1'b1, '0, 32'h0000_4000 + 32'(i * 8), 1'b0, 6'(30 + i), src_val[i],
                       12'(i), sq_pkg::mem_size_t'(i % 3));
        end
        // head is committed long before its data arrives
        for (int i = 0; i < 4; i++) commit_one();
        for (int i = 3; i >= 0; i--) broadcast(6'(30 + i), src_val[i]);
        wait_drain();
        finish_test("reverse wake-up keeps program order", start_err);
    endtask

    task automatic test_flush();
        int start_err;
        start_err = err_cnt;
        for (int i = 0; i < 5; i++) begin
            send_store(1'b1, '0, 32'h0000_5000 + 32'(i * 4), 1'b1, '0, $random(seed),
                       12'h000, sq_pkg::mem_word);
        end
        repeat (8) @(negedge clock);
        commit_one();
        commit_one();
        do_flush();
        if (alloc_idx !== tail_model) begin
            $display("ERROR alloc_idx expected %h actual %h", tail_model, alloc_idx);
            err_cnt++;
        end
        wait_drain();
        send_store(1'b1, '0, 32'h0000_5100, 1'b1, '0, $random(seed), 12'h002,
                   sq_pkg::mem_half);
        commit_one();
        wait_drain();
        finish_test("flush keeps committed stores", start_err);
    endtask

    task automatic test_no_commit();
        int   start_err;
        logic seen;
        start_err = err_cnt;
        seen      = 1'b0;
        send_store(1'b1, '0, 32'h0000_6000, 1'b1, '0, $random(seed), 12'h000, sq_pkg::mem_word);
        send_store(1'b1, '0, 32'h0000_6004, 1'b1, '0, $random(seed), 12'h001, sq_pkg::mem_byte);
        for (int i = 0; i < 20; i++) begin
            @(negedge clock);
            if (mem_req && !seen) begin
                $display("mem_req rose for a store that was never committed");
                err_cnt++;
                seen = 1'b1;
            end
        end
        do_flush();
        if (alloc_idx !== tail_model) begin
            $display("ERROR alloc_idx expected %h actual %h", tail_model, alloc_idx);
            err_cnt++;
        end
        finish_test("no write without commit", start_err);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst_n          = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb            = '0;
        commit         = 1'b0;
        mem_ack        = 1'b0;
        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        @(negedge clock);

        test_after_reset();
        test_ready_sizes();
        test_cdb_wakeup();
        test_rs_full();
        test_reverse_wakeup();
        test_flush();
        test_no_commit();

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
hdl/sq_pkg.sv
hdl/psel_gen.sv
hdl/rs_sq.sv
hdl/store_agen.sv
hdl/store_queue.sv
hdl/store_unit_top.sv
tb/tb_store_unit.sv

// File: Bender.yml
package:
  name: store_unit

sources:
  - hdl/sq_pkg.sv
  - hdl/psel_gen.sv
  - hdl/rs_sq.sv
  - hdl/store_agen.sv
  - hdl/store_queue.sv
  - hdl/store_unit_top.sv
  - target: test
    files:
      - tb/tb_store_unit.sv
